/* video_params.svh */
// raster geometry, blanking window, sync position and reset line macros
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// frame size in cen ticks and lines
`define VID_HTOTAL      512
`define VID_VTOTAL      262

// visible columns 64..447 give 384 pixels
`define VID_HB_END      64
`define VID_HB_START    448

// visible lines 14..237 give 224 lines
`define VID_VB_END      14
`define VID_VB_START    238

// hsync placement, end wraps round to column 13
`define VID_HS_START    487
`define VID_HS_LEN      38

// vsync edges, only looked at on an hsync rise
`define VID_VS_START    251
`define VID_VS_END      255

// display lines that kick off a render of the line after them
`define VID_START_FIRST 13
`define VID_START_LAST  236

// counters come out of reset in vertical blank
`define VID_RESET_LINE  240

`endif

/* video_pkg.sv */
// shared widths, sync bus and video output structs, fetch FSM states
`default_nettype none

package video_pkg;

    typedef logic [8:0] hcount_t;   // pixel column, 0..511
    typedef logic [8:0] vcount_t;   // line number, 0..261
    typedef logic [7:0] pixel_t;    // palette index
    typedef logic [7:0] scroll_t;   // scroll offset in pixels or lines

    // sync and blanking levels, all active high
    typedef struct packed {
        logic hs;
        logic vs;
        logic hb;
        logic vb;
    } syncBus_t;

    // what leaves the board, 12 bits
    typedef struct packed {
        syncBus_t sync;
        pixel_t   pixel;
    } videoOut_t;

    // scanline fill sequencer
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_RUN  = 2'd1,
        FETCH_DONE = 2'd2
    } fetchState_t;

    // level set while in reset, both blanks on and no sync
    localparam syncBus_t syncBlank = '{hs: 1'b0, vs: 1'b0, hb: 1'b1, vb: 1'b1};

endpackage

`default_nettype wire

/* video_timing.sv */
// raster counters, render line pipeline, sync and blanking generation, line start pulse
`timescale 1ns/1ps
`default_nettype none

`include "video_params.svh"

module video_timing (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cen,
    output video_pkg::hcount_t   hdump,
    output video_pkg::vcount_t   vdump,
    output video_pkg::vcount_t   vrender,
    output logic                 start,
    output video_pkg::syncBus_t  sync
);

    // geometry as typed constants so compares stay 9 bits wide
    localparam video_pkg::hcount_t lastCol   = video_pkg::hcount_t'(`VID_HTOTAL - 1);
    localparam video_pkg::vcount_t lastLine  = video_pkg::vcount_t'(`VID_VTOTAL - 1);
    localparam video_pkg::hcount_t hbEnd     = video_pkg::hcount_t'(`VID_HB_END);
    localparam video_pkg::hcount_t hbStart   = video_pkg::hcount_t'(`VID_HB_START);
    localparam video_pkg::vcount_t vbEnd     = video_pkg::vcount_t'(`VID_VB_END);
    localparam video_pkg::vcount_t vbStart   = video_pkg::vcount_t'(`VID_VB_START);
    localparam video_pkg::hcount_t hsStart   = video_pkg::hcount_t'(`VID_HS_START);
    localparam video_pkg::hcount_t hsEnd     =
        video_pkg::hcount_t'((`VID_HS_START + `VID_HS_LEN) % `VID_HTOTAL);  // 13
    localparam video_pkg::vcount_t vsStart   = video_pkg::vcount_t'(`VID_VS_START);
    localparam video_pkg::vcount_t vsEnd     = video_pkg::vcount_t'(`VID_VS_END);
    localparam video_pkg::vcount_t startLo   = video_pkg::vcount_t'(`VID_START_FIRST);
    localparam video_pkg::vcount_t startHi   = video_pkg::vcount_t'(`VID_START_LAST);
    localparam video_pkg::vcount_t resetLine = video_pkg::vcount_t'(`VID_RESET_LINE);

    video_pkg::vcount_t vrender1;   // two lines ahead of display
    logic               lineEnd;    // last column of the line

    assign lineEnd = (hdump == lastCol);

    // column counter and the three stage line pipeline
    always_ff @(posedge clk) begin
        if (reset) begin
            hdump    <= '0;
            vdump    <= resetLine;
            vrender  <= video_pkg::vcount_t'(resetLine + 9'd1);
            vrender1 <= video_pkg::vcount_t'(resetLine + 9'd2);
        end else if (cen) begin
            hdump <= lineEnd ? '0 : video_pkg::hcount_t'(hdump + 9'd1);
            if (lineEnd) begin
                vrender1 <= (vrender1 == lastLine) ? '0
                          : video_pkg::vcount_t'(vrender1 + 9'd1);
                vrender  <= vrender1;   // shift down the pipe
                vdump    <= vrender;
            end
        end
    end

    // start is one clk wide even when cen is slower than clk
    always_ff @(posedge clk) begin
        start <= 1'b0;
        if (!reset && cen && lineEnd) begin
            // vrender here becomes the new vdump
            start <= (vrender >= startLo) && (vrender <= startHi);
        end
    end

    // sync and blanking, one cen tick behind the counters
    always_ff @(posedge clk) begin
        if (reset) begin
            sync <= video_pkg::syncBlank;
        end else if (cen) begin
            sync.hb <= (hdump >= hbStart) || (hdump < hbEnd);
            sync.vb <= (vdump >= vbStart) || (vdump < vbEnd);   // 224 lines open
            if (hdump == hsStart) begin
                sync.hs <= 1'b1;
                // vsync edges ride on the hsync rise
                if (vdump == vsStart) begin
                    sync.vs <= 1'b1;
                end
                if (vdump == vsEnd) begin
                    sync.vs <= 1'b0;
                end
            end
            if (hdump == hsEnd) begin
                sync.hs <= 1'b0;    // 38 ticks after the rise
            end
        end
    end

endmodule

`default_nettype wire

/* line_fetch.sv */
// scanline fill FSM writing the scrolled xor test pattern into the line buffer
`timescale 1ns/1ps
`default_nettype none

`include "video_params.svh"

module line_fetch (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  video_pkg::vcount_t  vrender,
    input  video_pkg::scroll_t  scrollX,
    input  video_pkg::scroll_t  scrollY,
    output logic                wrEn,
    output logic                wrBank,
    output video_pkg::hcount_t  wrAddr,
    output video_pkg::pixel_t   wrData
);

    // 384 visible pixels, columns 0..383 of the buffer
    localparam video_pkg::hcount_t lastCol =
        video_pkg::hcount_t'(`VID_HB_START - `VID_HB_END - 1);

    video_pkg::fetchState_t state;
    video_pkg::hcount_t     col;        // buffer column being written
    video_pkg::vcount_t     lineReg;    // line being rendered
    video_pkg::scroll_t     scrollXReg;
    video_pkg::scroll_t     scrollYReg;
    video_pkg::pixel_t      colTerm;
    video_pkg::pixel_t      lineTerm;
    logic                   accept;     // start taken this clk

    assign accept = (state == video_pkg::FETCH_IDLE) && start;

    // sequencer, runs every clk regardless of cen
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= video_pkg::FETCH_IDLE;
            col   <= '0;
        end else begin
            case (state)
                video_pkg::FETCH_IDLE: begin
                    if (start) begin
                        state <= video_pkg::FETCH_RUN;
                        col   <= '0;
                    end
                end
                video_pkg::FETCH_RUN: begin
                    if (col == lastCol) begin
                        state <= video_pkg::FETCH_DONE;   // last pixel goes out now
                    end else begin
                        col <= video_pkg::hcount_t'(col + 9'd1);
                    end
                end
                video_pkg::FETCH_DONE: begin
                    state <= video_pkg::FETCH_IDLE;   // one clk gap before idle
                end
                default: begin
                    state <= video_pkg::FETCH_IDLE;
                end
            endcase
        end
    end

    // line and scroll are frozen for the whole fill
    always_ff @(posedge clk) begin
        if (accept) begin
            lineReg    <= vrender;
            scrollXReg <= scrollX;
            scrollYReg <= scrollY;
        end
    end

    // pattern terms wrap mod 256
    assign colTerm  = video_pkg::pixel_t'(col[7:0] + scrollXReg);
    assign lineTerm = video_pkg::pixel_t'(lineReg[7:0] + scrollYReg);

    assign wrEn   = (state == video_pkg::FETCH_RUN);
    assign wrBank = lineReg[0];     // odd lines go to bank 1
    assign wrAddr = col;
    assign wrData = colTerm ^ lineTerm;

endmodule

`default_nettype wire

/* line_buffer.sv */
// two bank scanline RAM with a write port and a registered enabled read port
`timescale 1ns/1ps
`default_nettype none

`include "video_params.svh"

module line_buffer (
    input  logic                clk,
    input  logic                wrEn,
    input  logic                wrBank,
    input  video_pkg::hcount_t  wrAddr,
    input  video_pkg::hcount_t  rdAddr,
    input  video_pkg::pixel_t   wrData,
    input  logic                rdBank,
    input  logic                rdEn,
    output video_pkg::pixel_t   rdData
);

    // one full line per bank, blank columns included
    localparam int depth = `VID_HTOTAL;

    // bank 0 holds even lines and bank 1 odd lines
    video_pkg::pixel_t mem [2][depth];

    // fill side, one pixel per clk while the fetch runs
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrBank][wrAddr] <= wrData;
        end
    end

    // display side only moves on pixel ticks
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdBank][rdAddr];  // one cen tick of latency
        end
    end

    // banks never collide since fetch writes the line after the one shown

endmodule

`default_nettype wire

/* pixel_out.sv */
// display bank read addressing, pixel blanking and sync alignment into videoOut
`timescale 1ns/1ps
`default_nettype none

`include "video_params.svh"

module pixel_out (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cen,
    input  video_pkg::hcount_t    hdump,
    input  video_pkg::vcount_t    vdump,
    input  video_pkg::syncBus_t   syncIn,
    input  video_pkg::pixel_t     rdData,
    output video_pkg::hcount_t    rdAddr,
    output logic                  rdBank,
    output video_pkg::videoOut_t  videoOut
);

    // first visible column maps to buffer column 0
    localparam video_pkg::hcount_t visStart = video_pkg::hcount_t'(`VID_HB_END);

    logic              blank;
    video_pkg::pixel_t shown;

    // wraps in blank columns, those pixels get forced to 0 anyway
    assign rdAddr = video_pkg::hcount_t'(hdump - visStart);
    assign rdBank = vdump[0];   // the bank filled during the previous line

    // syncIn already trails hdump by one tick, same as rdData
    assign blank = syncIn.hb || syncIn.vb;
    assign shown = blank ? '0 : rdData;

    // second tick of the pipe, sync and pixel leave together
    always_ff @(posedge clk) begin
        if (reset) begin
            videoOut.sync  <= video_pkg::syncBlank;
            videoOut.pixel <= '0;
        end else if (cen) begin
            videoOut.sync  <= syncIn;   // held back one tick to sit with the pixel
            videoOut.pixel <= shown;
        end
    end

endmodule

`default_nettype wire

/* video_top.sv */
// video subsystem top wiring timing, line fetch, line buffer and output stage
`timescale 1ns/1ps
`default_nettype none

module video_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cen,
    input  video_pkg::scroll_t    scrollX,
    input  video_pkg::scroll_t    scrollY,
    output video_pkg::videoOut_t  videoOut
);

    // raster position
    video_pkg::hcount_t  hdump;
    video_pkg::vcount_t  vdump;
    video_pkg::vcount_t  vrender;
    logic                start;
    video_pkg::syncBus_t sync;

    // fill port
    logic                wrEn;
    logic                wrBank;
    video_pkg::hcount_t  wrAddr;
    video_pkg::pixel_t   wrData;

    // display port
    video_pkg::hcount_t  rdAddr;
    logic                rdBank;
    video_pkg::pixel_t   rdData;

    video_timing uTiming (
        .clk     (clk),
        .reset   (reset),
        .cen     (cen),
        .hdump   (hdump),
        .vdump   (vdump),
        .vrender (vrender),
        .start   (start),
        .sync    (sync)
    );

    line_fetch uFetch (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .vrender (vrender),
        .scrollX (scrollX),
        .scrollY (scrollY),
        .wrEn    (wrEn),
        .wrBank  (wrBank),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    line_buffer uBuffer (
        .clk     (clk),
        .wrEn    (wrEn),
        .wrBank  (wrBank),
        .wrAddr  (wrAddr),
        .rdAddr  (rdAddr),
        .wrData  (wrData),
        .rdBank  (rdBank),
        .rdEn    (cen),     // read only on pixel ticks
        .rdData  (rdData)
    );

    pixel_out uOut (
        .clk      (clk),
        .reset    (reset),
        .cen      (cen),
        .hdump    (hdump),
        .vdump    (vdump),
        .syncIn   (sync),
        .rdData   (rdData),
        .rdAddr   (rdAddr),
        .rdBank   (rdBank),
        .videoOut (videoOut)
    );

endmodule

`default_nettype wire

/* video_sva.sv */
// bound assertions on hsync width, vsync edges, fetch write burst and start spacing
`timescale 1ns/1ps
`default_nettype none

`include "video_params.svh"

module video_sva (
    input logic                clk,
    input logic                reset,
    input logic                cen,
    input video_pkg::syncBus_t sync,
    input logic                start,
    input logic                wrEn
);

    logic [5:0] hsTicks;    // cen ticks seen with hsync high
    logic [9:0] wrLen;      // clk cycles in the current write burst
    int         failCount = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            hsTicks <= '0;
            wrLen   <= '0;
        end else begin
            if (cen) begin
                hsTicks <= sync.hs ? hsTicks + 6'd1 : '0;
            end
            wrLen <= wrEn ? wrLen + 10'd1 : '0;   // fill runs on every clk
        end
    end

    // width in pixel ticks, independent of the cen rate
    hsWidthChk: assert property (@(posedge clk) disable iff (reset)
        $fell(sync.hs) |-> hsTicks == 6'(`VID_HS_LEN))
    else begin
        failCount++;
        $error("hsync lasted %0d cen ticks", hsTicks);
    end

    // vsync edges only ride on an hsync rise
    vsEdgeChk: assert property (@(posedge clk) disable iff (reset)
        $changed(sync.vs) |-> $rose(sync.hs))
    else begin
        failCount++;
        $error("vsync moved without an hsync rise");
    end

    // fsm leaves idle on the start clk, wrEn is up the next one
    fillBeginChk: assert property (@(posedge clk) disable iff (reset)
        start |=> wrEn)
    else begin
        failCount++;
        $error("no write burst after start");
    end

    fillLenChk: assert property (@(posedge clk) disable iff (reset)
        $fell(wrEn) |-> wrLen == 10'(`VID_HB_START - `VID_HB_END))
    else begin
        failCount++;
        $error("write burst lasted %0d clk", wrLen);
    end

    // busy covers the run state and the done clk after it
    startIdleChk: assert property (@(posedge clk) disable iff (reset)
        start |-> !wrEn && !$past(wrEn))
    else begin
        failCount++;
        $error("start arrived while the fetch was busy");
    end

endmodule

bind video_top video_sva uSva (
    .clk   (clk),
    .reset (reset),
    .cen   (cen),
    .sync  (sync),
    .start (start),
    .wrEn  (wrEn)
);

`default_nettype wire

/* tb_video.sv */
// testbench for video_top with clock, reset, LFSR, raster monitor, directed tests and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "video_params.svh"

module tb_video;

    localparam int visCols    = `VID_HB_START - `VID_HB_END;   // 384 pixels a line
    localparam int visLines   = `VID_VB_START - `VID_VB_END;   // 224 lines a frame
    localparam int frameTicks = `VID_HTOTAL * `VID_VTOTAL;
    localparam video_pkg::syncBus_t blankSync = '{hs: 1'b0, vs: 1'b0, hb: 1'b1, vb: 1'b1};

    logic                 clk;
    logic                 reset;
    logic                 cen;
    video_pkg::scroll_t   scrollX;
    video_pkg::scroll_t   scrollY;
    video_pkg::videoOut_t videoOut;

    video_pkg::videoOut_t prevOut;      // output after the previous cen tick
    video_pkg::videoOut_t curOut;
    logic                 altCen;       // cen on every second clk
    logic [31:0]          lfsr;
    int                   errors;
    int                   checks;
    int                   tests;
    int                   errAtStart;
    int                   col;          // visible column since the hb fall
    int                   lineIdx;      // visible line since the vb fall
    int                   hsHigh;
    int                   hbLow;
    int                   lineTicks;    // cen ticks since the last hs rise
    bit                   lineOpen;     // counting from a real hs rise

    video_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .cen      (cen),
        .scrollX  (scrollX),
        .scrollY  (scrollY),
        .videoOut (videoOut)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // six frames at half rate plus slack
    initial begin
        #(64'd6 * `VID_HTOTAL * `VID_VTOTAL * 2 * 20 + 64'd100_000);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomByte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsrStep(lfsr);
            b    = {b[6:0], lfsr[0]};   // one step per bit
        end
    endtask

    function automatic video_pkg::pixel_t patternPixel(input int c, input int l);
        return video_pkg::pixel_t'(((c + scrollX) % 256) ^ ((l + scrollY) % 256));
    endfunction

    function automatic bit hsRise();
        return !prevOut.sync.hs && curOut.sync.hs;
    endfunction

    function automatic bit vsRise();
        return !prevOut.sync.vs && curOut.sync.vs;
    endfunction

    task automatic checkPixel(input string name, input video_pkg::pixel_t got,
                              input video_pkg::pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic checkSync(input string name, input video_pkg::syncBus_t got,
                             input video_pkg::syncBus_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic checkCount(input string name, input video_pkg::hcount_t got,
                              input video_pkg::hcount_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s exp %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic plainError(input string what);
        errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic endTest(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - errAtStart);
        errAtStart = errors;
    endtask

    // one pixel tick, outputs read 2 ns after the edge
    task automatic nextTick();
        if (altCen) begin
            cen = 1'b0;
            @(posedge clk);
            #2;
        end
        cen = 1'b1;
        @(posedge clk);
        #2;
        prevOut = curOut;
        curOut  = videoOut;
    endtask

    // per line hs and hb widths, checked at each hs rise
    task automatic trackLine();
        if (hsRise()) begin
            if (lineOpen) begin
                checkCount("hs high ticks", video_pkg::hcount_t'(hsHigh),
                           video_pkg::hcount_t'(`VID_HS_LEN));
                checkCount("hb low ticks", video_pkg::hcount_t'(hbLow),
                           video_pkg::hcount_t'(visCols));
                // a line of 512 ticks ends on column 511
                checkCount("line last column", video_pkg::hcount_t'(lineTicks - 1),
                           video_pkg::hcount_t'(`VID_HTOTAL - 1));
            end
            lineOpen  = 1'b1;
            hsHigh    = 0;
            hbLow     = 0;
            lineTicks = 0;
        end
        hsHigh += int'(curOut.sync.hs);
        hbLow  += int'(!curOut.sync.hb);
        lineTicks++;
    endtask

    task automatic monitorPixel();
        if (prevOut.sync.vb && !curOut.sync.vb) begin
            lineIdx = -1;
        end
        if (prevOut.sync.hb && !curOut.sync.hb && !curOut.sync.vb) begin
            lineIdx++;
            col = 0;
        end
        if (curOut.sync.hb || curOut.sync.vb) begin
            checkPixel("blanked pixel", curOut.pixel, '0);
        end else begin
            checkPixel("pixel", curOut.pixel, patternPixel(col, `VID_VB_END + lineIdx));
            col++;
        end
    endtask

    task automatic newScroll();
        randomByte(scrollX);
        randomByte(scrollY);
    endtask

    // runs from one vs rise to the next, checking sync counts and every pixel
    task automatic watchFrame(input bit scrollEachFrame);
        int hsCount;
        int vsLines;
        int openLines;
        int n;
        hsCount   = 0;
        vsLines   = 0;
        openLines = 0;
        n         = 0;
        do begin
            nextTick();
            n++;
            trackLine();
            monitorPixel();
            if (curOut.sync.vs != prevOut.sync.vs && !hsRise()) begin
                plainError("vsync changed away from an hsync rise");
            end
            if (hsRise()) begin
                hsCount++;
                vsLines += int'(curOut.sync.vs);
            end
            if (prevOut.sync.hb && !curOut.sync.hb && !curOut.sync.vb) begin
                openLines++;
            end
            if (scrollEachFrame && !prevOut.sync.vb && curOut.sync.vb) begin
                newScroll();    // visible area is over for this frame
            end
        end while (!vsRise() && n < frameTicks + `VID_HTOTAL);
        if (!vsRise()) begin
            plainError("no vsync rise within a frame");
        end
        checkCount("hs per frame", video_pkg::hcount_t'(hsCount),
                   video_pkg::hcount_t'(`VID_VTOTAL));
        checkCount("vs lines", video_pkg::hcount_t'(vsLines),
                   video_pkg::hcount_t'(`VID_VS_END - `VID_VS_START));
        checkCount("open lines", video_pkg::hcount_t'(openLines),
                   video_pkg::hcount_t'(visLines));
    endtask

    task automatic resetStateTest();
        int n;
        repeat (10) @(posedge clk);
        #2;
        checkSync("sync in reset", videoOut.sync, blankSync);
        checkPixel("pixel in reset", videoOut.pixel, '0);
        reset   = 1'b0;
        curOut  = videoOut;
        prevOut = videoOut;
        // hb stays high for the first 64 columns plus the pipe
        repeat (`VID_HB_END) begin
            nextTick();
            checkSync("sync after reset", curOut.sync, blankSync);
            checkPixel("pixel after reset", curOut.pixel, '0);
        end
        n = 0;
        while (curOut.sync.vb && n < 40 * `VID_HTOTAL) begin
            nextTick();
            n++;
            checkPixel("pixel in vblank", curOut.pixel, '0);
        end
        if (curOut.sync.vb) begin
            plainError("vblank never ended after reset");
        end
        endTest("reset state");
    endtask

    task automatic lineTimingTest();
        lineOpen = 1'b0;
        repeat (5 * `VID_HTOTAL) begin
            nextTick();
            trackLine();
        end
        endTest("line timing");
    endtask

    task automatic frameTimingTest();
        int n;
        lineOpen = 1'b0;
        n = 0;
        while (!vsRise() && n < frameTicks + `VID_HTOTAL) begin
            nextTick();
            trackLine();
            n++;
        end
        if (!vsRise()) begin
            plainError("no vsync rise while lining up on a frame");
        end
        watchFrame(1'b0);
        endTest("frame timing");
    endtask

    task automatic scrollPatternTest();
        newScroll();    // at a vs rise, so vb is high
        watchFrame(1'b1);
        watchFrame(1'b1);
        endTest("scrolled pattern");
    endtask

    task automatic halfRateTest();
        altCen = 1'b1;
        watchFrame(1'b1);
        endTest("half rate cen");
    endtask

    initial begin
        reset      = 1'b1;
        cen        = 1'b0;
        scrollX    = '0;
        scrollY    = '0;
        altCen     = 1'b0;
        lfsr       = 32'h30dc7401;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        errAtStart = 0;
        col        = 0;
        lineIdx    = 0;
        hsHigh     = 0;
        hbLow      = 0;
        lineTicks  = 0;
        lineOpen   = 1'b0;
        resetStateTest();
        lineTimingTest();
        frameTimingTest();
        scrollPatternTest();
        halfRateTest();
        errors += u_dut.uSva.failCount;     // bound assertion failures count too
        $display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
                 tests, checks, u_dut.uSva.failCount, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
video_pkg.sv
video_timing.sv
line_fetch.sv
line_buffer.sv
pixel_out.sv
video_top.sv
video_sva.sv
tb_video.sv
